// File: common/risk_pkg.sv
// risk package
// widths and types shared by the pre-trade risk gate and both ledgers

package risk_pkg;

  // order and cancel quantities, plus the running totals built from them
  localparam int AMOUNT_W = 16;

  // per-client exposure ceiling, as written by the cpu
  localparam int LIMIT_W = 32;

  typedef logic [AMOUNT_W-1:0] amount_t;
  typedef logic [LIMIT_W-1:0]  limit_t;

  // one extra bit so a sum of two amounts shows its carry
  typedef logic [AMOUNT_W:0] amount_sum_t;

  // totals stick here instead of wrapping
  localparam amount_t AMOUNT_SAT = '1;

endpackage

// File: hw/order_book/order_ledger.sv
// order ledger
// per-client trading limit and accumulated order total
// one registered read port for the gate, one commit port that adds or overwrites
`timescale 1ns/1ps

module order_ledger import risk_pkg::*; #(
  parameter int NUM_CLIENTS = 32,
  parameter int CLIENT_W    = 5
) (
  input  logic                clk,
  input  logic                reset,

  // read side, answer lands one cycle after rd_client
  input  logic [CLIENT_W-1:0] rd_client,
  output limit_t              rd_limit,
  output amount_t             rd_accum,

  // commit side, driven by the gate on its response edge
  input  logic                commit_order,     // add commit_amount to accum
  input  logic                commit_limit,     // overwrite the limit
  input  logic [CLIENT_W-1:0] commit_client,
  input  amount_t             commit_amount,
  input  limit_t              commit_limit_val
);

  limit_t  limit_mem [NUM_CLIENTS];
  amount_t accum_mem [NUM_CLIENTS];

  amount_t accum_next;   // stored total plus the committed delta

  // gate has already ruled out a carry, so a plain add is enough
  assign accum_next = accum_mem[commit_client] + commit_amount;

  // limit array
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_CLIENTS; i++) begin
        limit_mem[i] <= '0;   // every client starts unable to trade
      end
    end else if (commit_limit) begin
      limit_mem[commit_client] <= commit_limit_val;
    end
  end

  // accumulated order array
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_CLIENTS; i++) begin
        accum_mem[i] <= '0;
      end
    end else if (commit_order) begin
      accum_mem[commit_client] <= accum_next;   // only the delta comes in
    end
  end

  // registered read
  // sees the array as it was before any commit on the same edge,
  // the gate never reads and commits in the same cycle anyway
  always_ff @(posedge clk) begin
    rd_limit <= limit_mem[rd_client];
    rd_accum <= accum_mem[rd_client];
  end

endmodule

// File: hw/order_book/cancel_ledger.sv
// cancel ledger
// exchange-side wishbone slave keeping per-client cancelled totals
// totals saturate, the gate gets a registered read of the same array
`timescale 1ns/1ps

module cancel_ledger import risk_pkg::*; #(
  parameter int NUM_CLIENTS = 32,
  parameter int CLIENT_W    = 5
) (
  input  logic                clk,
  input  logic                reset,

  // exchange bus, write only
  input  logic                ex_cyc,
  input  logic                ex_stb,
  input  logic [CLIENT_W-1:0] ex_adr,     // client
  input  amount_t             ex_dat_w,   // cancelled quantity
  output logic                ex_ack,

  // gate read port
  input  logic [CLIENT_W-1:0] rd_client,
  output amount_t             rd_cancelled
);

  amount_t     cancel_mem [NUM_CLIENTS];
  logic        busy;       // request sampled, ack goes out next edge
  amount_sum_t cancel_sum;

  // master holds adr and data until ack, so no payload latch
  assign cancel_sum = {1'b0, cancel_mem[ex_adr]} + {1'b0, ex_dat_w};

  // handshake, one request in flight
  always_ff @(posedge clk) begin
    if (reset) begin
      busy   <= 1'b0;
      ex_ack <= 1'b0;
    end else begin
      ex_ack <= busy;   // single-cycle pulse
      busy   <= ~busy & ~ex_ack & ex_cyc & ex_stb;
    end
  end

  // cancelled totals, written on the ack edge
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_CLIENTS; i++) begin
        cancel_mem[i] <= '0;
      end
    end else if (busy) begin
      // carry out means we passed the top
      cancel_mem[ex_adr] <= cancel_sum[AMOUNT_W] ? AMOUNT_SAT : cancel_sum[AMOUNT_W-1:0];
    end
  end

  // gate read, a cancel on this same edge shows up on the next read
  always_ff @(posedge clk) begin
    rd_cancelled <= cancel_mem[rd_client];
  end

endmodule

// File: hw/risk_gate.sv
// risk gate
// cpu wishbone slave that reads both ledgers and rules on orders and limit raises
// fixed latency, ack or err three edges after the request is sampled
`timescale 1ns/1ps

module risk_gate import risk_pkg::*; #(
  parameter int NUM_CLIENTS = 32,
  parameter int CLIENT_W    = 5
) (
  input  logic                clk,
  input  logic                reset,

  // cpu bus, adr top bit picks order or limit
  input  logic                cpu_cyc,
  input  logic                cpu_stb,
  input  logic                cpu_we,
  input  logic [CLIENT_W:0]   cpu_adr,
  input  logic [31:0]         cpu_dat_w,
  output logic [31:0]         cpu_dat_r,
  output logic                cpu_ack,
  output logic                cpu_err,

  // ledger reads
  output logic [CLIENT_W-1:0] rd_client,
  input  limit_t              rd_limit,
  input  amount_t             rd_accum,
  input  amount_t             rd_cancelled,

  // ledger commits
  output logic                commit_order,
  output logic                commit_limit,
  output logic [CLIENT_W-1:0] commit_client,
  output amount_t             commit_amount,
  output limit_t              commit_limit_val
);

  typedef enum logic [1:0] {
    st_idle,      // waiting for cyc&stb
    st_read,      // address out to both ledgers
    st_decide,    // ledger data arrives, captured here
    st_respond    // decision and commit
  } gate_state_t;

  gate_state_t state;

  logic                req;        // new request, not the tail of the last one
  logic                we_q;
  logic                op_q;       // 1 = limit update
  logic [CLIENT_W-1:0] client_q;
  limit_t              dat_q;

  limit_t              limit_q;
  amount_t             accum_q;
  amount_t             cancel_q;

  amount_sum_t         new_total;
  amount_sum_t         net_exposure;
  logic                over_sat;
  logic                exposure_ok;
  logic                order_ok;
  logic                raise_ok;
  logic                accept;

  // master keeps stb up while our ack is out, don't take it twice
  assign req = cpu_cyc & cpu_stb & ~cpu_ack & ~cpu_err;

  // control fsm and response strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_idle;
      cpu_ack <= 1'b0;
      cpu_err <= 1'b0;
    end else begin
      cpu_ack <= 1'b0;   // pulses only
      cpu_err <= 1'b0;
      case (state)
        st_idle: begin
          if (req) state <= st_read;
        end
        st_read:   state <= st_decide;
        st_decide: state <= st_respond;
        st_respond: begin
          cpu_ack <= accept;
          cpu_err <= ~accept;
          state   <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // request latch and ledger capture
  always_ff @(posedge clk) begin
    if (state == st_idle && req) begin
      we_q     <= cpu_we;
      op_q     <= cpu_adr[CLIENT_W];
      client_q <= cpu_adr[CLIENT_W-1:0];
      dat_q    <= cpu_dat_w;
    end
    if (state == st_decide) begin
      limit_q  <= rd_limit;
      accum_q  <= rd_accum;
      cancel_q <= rd_cancelled;
    end
    if (state == st_respond) begin
      // status word, writes just return zero
      cpu_dat_r <= we_q ? '0 : {accum_q, cancel_q};
    end
  end

  // ledgers see the latched client from the read state on
  assign rd_client = client_q;

  // order check
  assign new_total    = {1'b0, accum_q} + {1'b0, dat_q[AMOUNT_W-1:0]};
  assign over_sat     = new_total > {1'b0, AMOUNT_SAT};
  // cancels past the total count as zero exposure
  assign net_exposure = ({1'b0, cancel_q} > new_total) ? '0 : new_total - {1'b0, cancel_q};
  assign exposure_ok  = limit_q > limit_t'(net_exposure);   // strictly below
  assign order_ok     = ~over_sat & exposure_ok;

  // limits only ever go up
  assign raise_ok  = dat_q > limit_q;

  // reads always pass
  assign accept = ~we_q | (op_q ? raise_ok : order_ok);

  // commits land on the same edge as ack
  assign commit_order     = (state == st_respond) & accept & we_q & ~op_q;
  assign commit_limit     = (state == st_respond) & accept & we_q & op_q;
  assign commit_client    = client_q;
  assign commit_amount    = dat_q[AMOUNT_W-1:0];   // delta only
  assign commit_limit_val = dat_q;

endmodule

// File: hw/pretrade_risk_top.sv
// pre-trade risk top
// gate between the cpu bus and the two ledgers, exchange bus feeds cancels
`timescale 1ns/1ps

module pretrade_risk_top import risk_pkg::*; #(
  parameter int NUM_CLIENTS = 32,
  parameter int CLIENT_W    = 5
) (
  input  logic                clk,
  input  logic                reset,

  // cpu bus
  input  logic                cpu_cyc,
  input  logic                cpu_stb,
  input  logic                cpu_we,
  input  logic [CLIENT_W:0]   cpu_adr,
  input  logic [31:0]         cpu_dat_w,
  output logic [31:0]         cpu_dat_r,
  output logic                cpu_ack,
  output logic                cpu_err,

  // exchange bus
  input  logic                ex_cyc,
  input  logic                ex_stb,
  input  logic [CLIENT_W-1:0] ex_adr,
  input  amount_t             ex_dat_w,
  output logic                ex_ack
);

  logic [CLIENT_W-1:0] rd_client;      // shared read address
  limit_t              rd_limit;
  amount_t             rd_accum;
  amount_t             rd_cancelled;
  logic                commit_order;
  logic                commit_limit;
  logic [CLIENT_W-1:0] commit_client;
  amount_t             commit_amount;
  limit_t              commit_limit_val;

  order_ledger #(
    .NUM_CLIENTS (NUM_CLIENTS),
    .CLIENT_W    (CLIENT_W)
  ) u_order_ledger (
    .clk              (clk),
    .reset            (reset),
    .rd_client        (rd_client),
    .rd_limit         (rd_limit),
    .rd_accum         (rd_accum),
    .commit_order     (commit_order),
    .commit_limit     (commit_limit),
    .commit_client    (commit_client),
    .commit_amount    (commit_amount),
    .commit_limit_val (commit_limit_val)
  );

  cancel_ledger #(
    .NUM_CLIENTS (NUM_CLIENTS),
    .CLIENT_W    (CLIENT_W)
  ) u_cancel_ledger (
    .clk          (clk),
    .reset        (reset),
    .ex_cyc       (ex_cyc),
    .ex_stb       (ex_stb),
    .ex_adr       (ex_adr),
    .ex_dat_w     (ex_dat_w),
    .ex_ack       (ex_ack),
    .rd_client    (rd_client),
    .rd_cancelled (rd_cancelled)
  );

  risk_gate #(
    .NUM_CLIENTS (NUM_CLIENTS),
    .CLIENT_W    (CLIENT_W)
  ) u_risk_gate (
    .clk              (clk),
    .reset            (reset),
    .cpu_cyc          (cpu_cyc),
    .cpu_stb          (cpu_stb),
    .cpu_we           (cpu_we),
    .cpu_adr          (cpu_adr),
    .cpu_dat_w        (cpu_dat_w),
    .cpu_dat_r        (cpu_dat_r),
    .cpu_ack          (cpu_ack),
    .cpu_err          (cpu_err),
    .rd_client        (rd_client),
    .rd_limit         (rd_limit),
    .rd_accum         (rd_accum),
    .rd_cancelled     (rd_cancelled),
    .commit_order     (commit_order),
    .commit_limit     (commit_limit),
    .commit_client    (commit_client),
    .commit_amount    (commit_amount),
    .commit_limit_val (commit_limit_val)
  );

endmodule

// File: bench/risk_gate_props.sv
// risk gate bus properties
// bound into the gate, watches the cpu response strobes
`timescale 1ns/1ps

module risk_gate_props (
  input logic clk,
  input logic reset,
  input logic cpu_cyc,
  input logic cpu_stb,
  input logic cpu_ack,
  input logic cpu_err
);

  int   fail_count = 0;   // read by the testbench at the end
  logic resp;

  assign resp = cpu_ack | cpu_err;

  ack_err_apart: assert property (@(posedge clk) disable iff (reset) !(cpu_ack && cpu_err))
    else begin $error("cpu_ack and cpu_err high together"); fail_count++; end

  // response only answers a live request
  resp_in_cycle: assert property (@(posedge clk) disable iff (reset)
    resp |-> $past(cpu_cyc && cpu_stb))
    else begin $error("response without cyc and stb"); fail_count++; end

  resp_pulse: assert property (@(posedge clk) disable iff (reset) resp |=> !resp)
    else begin $error("response wider than one cycle"); fail_count++; end

  // driven on edge 3 after the sample, seen here one edge later
  resp_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(cpu_cyc && cpu_stb) |=> (!resp) [*3] ##1 resp)
    else begin $error("response not three cycles after the request"); fail_count++; end

endmodule

bind risk_gate risk_gate_props u_risk_gate_props (
  .clk     (clk),
  .reset   (reset),
  .cpu_cyc (cpu_cyc),
  .cpu_stb (cpu_stb),
  .cpu_ack (cpu_ack),
  .cpu_err (cpu_err)
);

// File: bench/pretrade_risk_tb.sv
// pre-trade risk testbench
// cpu and exchange bus tasks against a shadow model, directed checks then a random mix
`timescale 1ns/1ps

module pretrade_risk_tb import risk_pkg::*; ();

  localparam int NUM_CLIENTS  = 32;
  localparam int CLIENT_W     = 5;
  localparam int RESET_CYCLES = 16;
  localparam int RESP_WAIT    = 8;     // cycles before a response counts as missing
  localparam int NUM_RANDOM   = 600;
  localparam int NUM_DIRECTED = 2 * NUM_CLIENTS + 26;   // sweep of reads and orders, then 26
  localparam int CYCLE_LIMIT  = 20 * (NUM_DIRECTED + NUM_RANDOM) + RESET_CYCLES;

  typedef struct packed {
    logic        is_read;   // word only compared on reads
    logic        ack;
    logic        err;
    logic [31:0] word;
  } resp_t;

  logic                clk;
  logic                reset;
  logic                cpu_cyc;
  logic                cpu_stb;
  logic                cpu_we;
  logic [CLIENT_W:0]   cpu_adr;
  logic [31:0]         cpu_dat_w;
  logic [31:0]         cpu_dat_r;
  logic                cpu_ack;
  logic                cpu_err;
  logic                ex_cyc;
  logic                ex_stb;
  logic [CLIENT_W-1:0] ex_adr;
  amount_t             ex_dat_w;
  logic                ex_ack;

  // shadow state of the ledgers
  limit_t  model_limit  [NUM_CLIENTS];
  amount_t model_accum  [NUM_CLIENTS];
  amount_t model_cancel [NUM_CLIENTS];

  resp_t       exp_q[$];
  resp_t       act_q[$];
  int          checks;
  int          mismatches;
  int          missing;
  int          assert_fails;
  int          cycles;
  logic [31:0] rng_state;

  pretrade_risk_top #(
    .NUM_CLIENTS (NUM_CLIENTS),
    .CLIENT_W    (CLIENT_W)
  ) u_pretrade_risk_top (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns
  end

  // xorshift32, never zero once seeded
  function automatic logic [31:0] xorshift_next();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // {accept, read word} straight from the decision rules
  function automatic logic [32:0] ref_response(logic we, logic [CLIENT_W:0] adr,
                                               logic [31:0] dat);
    int unsigned client;
    longint      total;
    longint      net;
    logic        ok;
    client = adr[CLIENT_W-1:0];
    if (!we) return {1'b1, model_accum[client], model_cancel[client]};
    if (adr[CLIENT_W]) return {dat > model_limit[client], 32'h0};   // raise only
    total = longint'(model_accum[client]) + longint'(dat[15:0]);
    net   = total - longint'(model_cancel[client]);
    if (net < 0) net = 0;   // over-cancelled means no exposure
    ok = (total <= longint'(AMOUNT_SAT)) && (longint'(model_limit[client]) > net);
    return {ok, 32'h0};
  endfunction

  task automatic flag_check(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %0b, got %0b", $time, name, exp, act);
      mismatches++;
    end
  endtask

  task automatic amount_check(input string name, input amount_t exp, input amount_t act);
    checks++;
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %04h, got %04h", $time, name, exp, act);
      mismatches++;
    end
  endtask

  // one cpu cycle, model updated up front with the expected decision
  task automatic cpu_access(input logic we, input logic [CLIENT_W:0] adr, input logic [31:0] dat);
    resp_t       e;
    resp_t       a;
    logic [32:0] r;
    int          waited;
    r = ref_response(we, adr, dat);
    e = '{is_read: ~we, ack: r[32], err: ~r[32], word: r[31:0]};
    if (we && r[32] && adr[CLIENT_W]) model_limit[adr[CLIENT_W-1:0]] = dat;
    if (we && r[32] && !adr[CLIENT_W]) begin
      model_accum[adr[CLIENT_W-1:0]] = model_accum[adr[CLIENT_W-1:0]] + dat[15:0];
    end
    exp_q.push_back(e);
    @(negedge clk);
    cpu_cyc   = 1'b1;
    cpu_stb   = 1'b1;
    cpu_we    = we;
    cpu_adr   = adr;
    cpu_dat_w = dat;
    waited    = 0;
    do begin
      @(negedge clk);   // outputs settled since the rising edge
      waited++;
    end while (!(cpu_ack || cpu_err) && waited < RESP_WAIT);
    if (cpu_ack || cpu_err) begin
      a = '{is_read: ~we, ack: cpu_ack, err: cpu_err, word: cpu_dat_r};
      act_q.push_back(a);
    end else begin
      $display("no ack or err from the cpu port for address %02h at %0t ns", adr, $time);
      missing++;
      void'(exp_q.pop_back());
    end
    cpu_cyc = 1'b0;   // stb low for at least one edge
    cpu_stb = 1'b0;
    cpu_we  = 1'b0;
  endtask

  task automatic send_cancel(input logic [CLIENT_W-1:0] client, input amount_t amt);
    int waited;
    int sum;
    sum = int'(model_cancel[client]) + int'(amt);
    model_cancel[client] = (sum > int'(AMOUNT_SAT)) ? AMOUNT_SAT : amount_t'(sum);
    @(negedge clk);
    ex_cyc   = 1'b1;
    ex_stb   = 1'b1;
    ex_adr   = client;
    ex_dat_w = amt;
    waited   = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!ex_ack && waited < RESP_WAIT);
    if (ex_ack) checks++;
    else begin
      $display("no ack from the exchange port for client %0d at %0t ns", client, $time);
      missing++;
    end
    ex_cyc = 1'b0;
    ex_stb = 1'b0;
  endtask

  // compare process, pairs each response with its expected one
  initial begin : compare_proc
    resp_t e;
    resp_t a;
    forever begin
      wait (act_q.size() > 0);
      e = exp_q.pop_front();
      a = act_q.pop_front();
      flag_check("cpu_ack", e.ack, a.ack);
      flag_check("cpu_err", e.err, a.err);
      if (e.is_read) begin
        amount_check("cpu_dat_r[31:16]", e.word[31:16], a.word[31:16]);   // accumulated
        amount_check("cpu_dat_r[15:0]", e.word[15:0], a.word[15:0]);      // cancelled
      end
    end
  end

  // run limit
  initial begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run still going after %0d cycles", cycles);
    $display("%0d checks, %0d mismatches, %0d missing responses", checks, mismatches, missing);
    $display("Testbench failed");
    $finish;
  end

  initial begin : stimulus
    logic [31:0]         r;
    logic [31:0]         v;
    logic [CLIENT_W-1:0] client;
    reset     = 1'b1;
    cpu_cyc   = 1'b0;
    cpu_stb   = 1'b0;
    cpu_we    = 1'b0;
    cpu_adr   = '0;
    cpu_dat_w = '0;
    ex_cyc    = 1'b0;
    ex_stb    = 1'b0;
    ex_adr    = '0;
    ex_dat_w  = '0;
    rng_state = 32'd5155;
    checks     = 0;
    mismatches = 0;
    missing    = 0;
    for (int i = 0; i < NUM_CLIENTS; i++) begin
      model_limit[i]  = '0;
      model_accum[i]  = '0;
      model_cancel[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // everything zero out of reset, zero limit blocks any order
    for (int i = 0; i < NUM_CLIENTS; i++) cpu_access(1'b0, i, 32'h0);
    for (int i = 0; i < NUM_CLIENTS; i++) begin
      v = xorshift_next();
      cpu_access(1'b1, i, {16'h0, v[15:0] | 16'h1});   // never a zero amount
    end

    // limits only rise, 99 under 100 confirms the old limit held
    cpu_access(1'b1, 6'h23, 32'd100);
    cpu_access(1'b1, 6'h23, 32'd100);
    cpu_access(1'b1, 6'h23, 32'd50);
    cpu_access(1'b1, 6'h03, 32'd99);
    cpu_access(1'b1, 6'h03, 32'd1);   // reaches the limit

    // orders grow the total until the limit
    cpu_access(1'b1, 6'h27, 32'd1000);
    repeat (3) cpu_access(1'b1, 6'h07, 32'd300);
    cpu_access(1'b1, 6'h07, 32'd100);
    cpu_access(1'b0, 6'h07, 32'h0);
    cpu_access(1'b1, 6'h07, 32'd99);
    cpu_access(1'b0, 6'h07, 32'h0);

    // a cancel frees room for the rejected order
    cpu_access(1'b1, 6'h07, 32'd50);
    send_cancel(5'd7, 16'd100);
    cpu_access(1'b1, 6'h07, 32'd50);
    cpu_access(1'b0, 6'h07, 32'h0);
    send_cancel(5'd9, 16'hf000);
    send_cancel(5'd9, 16'h2000);      // past the top
    cpu_access(1'b0, 6'h09, 32'h0);
    send_cancel(5'd9, 16'd5);
    cpu_access(1'b0, 6'h09, 32'h0);

    // total overflow beats a huge limit
    cpu_access(1'b1, 6'h2c, 32'hffff_ffff);
    cpu_access(1'b1, 6'h0c, 32'h0000_ffff);
    cpu_access(1'b1, 6'h0c, 32'd1);
    cpu_access(1'b0, 6'h0c, 32'h0);

    // random mix over all clients
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r      = xorshift_next();
      v      = xorshift_next();
      client = r[CLIENT_W-1:0];
      case (r[7:5])
        3'd0, 3'd1, 3'd2: begin   // order, now and then a big one
          cpu_access(1'b1, {1'b0, client},
                     (v[31:28] == 4'h0) ? {16'h0, v[15:0]} : {20'h0, v[11:0]});
        end
        3'd3: begin               // raise half the time, else anything
          cpu_access(1'b1, {1'b1, client},
                     v[0] ? model_limit[client] + v[23:12] : {14'h0, v[17:0]});
        end
        3'd4, 3'd5: cpu_access(1'b0, {r[8], client}, 32'h0);
        default:    send_cancel(client, {6'h0, v[9:0]});
      endcase
    end

    wait (act_q.size() == 0);
    @(negedge clk);
    assert_fails = u_pretrade_risk_top.u_risk_gate.u_risk_gate_props.fail_count;
    $display("%0d checks, %0d mismatches, %0d missing responses, %0d assertion failures",
             checks, mismatches, missing, assert_fails);
    if (mismatches == 0 && missing == 0 && assert_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
common/risk_pkg.sv
hw/order_book/order_ledger.sv
hw/order_book/cancel_ledger.sv
hw/risk_gate.sv
hw/pretrade_risk_top.sv
bench/risk_gate_props.sv
bench/pretrade_risk_tb.sv

// File: Bender.yml
package:
  name: pretrade_risk

sources:
  # package first, then ledgers, gate and top
  - files:
      - common/risk_pkg.sv
      - hw/order_book/order_ledger.sv
      - hw/order_book/cancel_ledger.sv
      - hw/risk_gate.sv
      - hw/pretrade_risk_top.sv

  # simulation only
  - target: test
    files:
      - bench/risk_gate_props.sv
      - bench/pretrade_risk_tb.sv
